/* ctrlPkg.sv */
package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [2:0] aluOpT;
    typedef logic [1:0] aluSrcAT;
    typedef logic [2:0] aluSrcBT;
    typedef logic [1:0] pcSrcT;
    typedef logic [1:0] regDstT;
    typedef logic [2:0] wbSrcT;

    localparam opcodeT OpRType = 6'b000000;
    localparam opcodeT OpAddi  = 6'b001000;
    localparam opcodeT OpAddiu = 6'b001001;
    localparam opcodeT OpBeq   = 6'b000100;
    localparam opcodeT OpBne   = 6'b000101;
    localparam opcodeT OpBle   = 6'b000110;
    localparam opcodeT OpBgt   = 6'b000111;

    localparam functT FunctAdd   = 6'b100000;
    localparam functT FunctAnd   = 6'b100100;
    localparam functT FunctSub   = 6'b100010;
    localparam functT FunctMult  = 6'b011000;
    localparam functT FunctDiv   = 6'b011010;
    localparam functT FunctMfhi  = 6'b010000;
    localparam functT FunctMflo  = 6'b010010;
    localparam functT FunctBreak = 6'b001101;

    localparam aluOpT AluAdd     = 3'b001;
    localparam aluOpT AluSub     = 3'b010;
    localparam aluOpT AluAnd     = 3'b011;
    localparam aluOpT AluCompare = 3'b111; // Sets gt, lt and et

    localparam aluSrcAT SrcAPc   = 2'b00;
    localparam aluSrcAT SrcARegA = 2'b01;

    localparam aluSrcBT SrcBRegB   = 3'b000;
    localparam aluSrcBT SrcBFour   = 3'b001;
    localparam aluSrcBT SrcBOffset = 3'b010; // Shifted sign-extended offset
    localparam aluSrcBT SrcBImm    = 3'b011;

    localparam pcSrcT PcAluResult = 2'b00;
    localparam pcSrcT PcAluOut    = 2'b10;

    localparam regDstT DstRd = 2'b00;
    localparam regDstT DstRt = 2'b11;

    localparam wbSrcT WbAluOut = 3'b000;
    localparam wbSrcT WbLo     = 3'b001;
    localparam wbSrcT WbHi     = 3'b010;

    typedef enum logic [1:0] {
        BrEq,
        BrNe,
        BrLe,
        BrGt
    } branchKindT;

    typedef enum logic [4:0] {
        Fetch,
        FetchPc,
        Precalc,
        Decode,
        ExecAdd,
        ExecSub,
        ExecAnd,
        SaveResult,
        AddImm,
        AddImmSave,
        MultStart,
        MultWait,
        MultResult,
        DivStart,
        DivWait,
        DivResult,
        Mfhi,
        Mflo,
        BranchCompare,
        BranchTake,
        BreakCalc,
        BreakPc
    } ctrlStateT;

endpackage

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  ctrlPkg::opcodeT     opcode,
    input  ctrlPkg::functT      funct,
    output ctrlPkg::ctrlStateT  decodedState,
    output ctrlPkg::branchKindT decodedBranch
);

    always_comb begin
        decodedState  = ctrlPkg::Fetch; // Unknown codes go back to fetch
        decodedBranch = ctrlPkg::BrEq;
        case (opcode)
            ctrlPkg::OpRType: begin
                case (funct)
                    ctrlPkg::FunctAdd:   decodedState = ctrlPkg::ExecAdd;
                    ctrlPkg::FunctSub:   decodedState = ctrlPkg::ExecSub;
                    ctrlPkg::FunctAnd:   decodedState = ctrlPkg::ExecAnd;
                    ctrlPkg::FunctMult:  decodedState = ctrlPkg::MultStart;
                    ctrlPkg::FunctDiv:   decodedState = ctrlPkg::DivStart;
                    ctrlPkg::FunctMfhi:  decodedState = ctrlPkg::Mfhi;
                    ctrlPkg::FunctMflo:  decodedState = ctrlPkg::Mflo;
                    ctrlPkg::FunctBreak: decodedState = ctrlPkg::BreakCalc;
                    default:             decodedState = ctrlPkg::Fetch;
                endcase
            end
            ctrlPkg::OpAddi,
            ctrlPkg::OpAddiu: begin
                decodedState = ctrlPkg::AddImm; // Overflow not trapped
            end
            ctrlPkg::OpBeq: begin
                decodedState  = ctrlPkg::BranchCompare;
                decodedBranch = ctrlPkg::BrEq;
            end
            ctrlPkg::OpBne: begin
                decodedState  = ctrlPkg::BranchCompare;
                decodedBranch = ctrlPkg::BrNe;
            end
            ctrlPkg::OpBle: begin
                decodedState  = ctrlPkg::BranchCompare;
                decodedBranch = ctrlPkg::BrLe;
            end
            ctrlPkg::OpBgt: begin
                decodedState  = ctrlPkg::BranchCompare;
                decodedBranch = ctrlPkg::BrGt;
            end
            default: begin
                decodedState  = ctrlPkg::Fetch;
                decodedBranch = ctrlPkg::BrEq;
            end
        endcase
    end

endmodule

/* controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer #(
    parameter int FetchWait = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::ctrlStateT  decodedState,
    input  ctrlPkg::branchKindT decodedBranch,
    input  logic                gt,
    input  logic                lt,
    input  logic                et,
    input  logic                multEnd,
    input  logic                divEnd,
    output ctrlPkg::ctrlStateT  state
);

    localparam int CntW = (FetchWait > 1) ? $clog2(FetchWait) : 1;

    ctrlPkg::ctrlStateT  nextState;
    ctrlPkg::branchKindT branchKind; // Kept from Decode for the compare cycle
    logic [CntW-1:0]     fetchCnt;
    logic                fetchDone;
    logic                takeBranch;

    assign fetchDone = (fetchCnt == CntW'(FetchWait - 1));

    always_comb begin
        case (branchKind)
            ctrlPkg::BrEq: takeBranch = et;
            ctrlPkg::BrNe: takeBranch = !et;
            ctrlPkg::BrLe: takeBranch = et || lt;
            ctrlPkg::BrGt: takeBranch = gt;
            default:       takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::Fetch: begin
                if (fetchDone) begin
                    nextState = ctrlPkg::FetchPc;
                end
            end
            ctrlPkg::FetchPc:    nextState = ctrlPkg::Precalc;
            ctrlPkg::Precalc:    nextState = ctrlPkg::Decode;
            ctrlPkg::Decode:     nextState = decodedState;
            ctrlPkg::ExecAdd,
            ctrlPkg::ExecSub,
            ctrlPkg::ExecAnd:    nextState = ctrlPkg::SaveResult;
            ctrlPkg::AddImm:     nextState = ctrlPkg::AddImmSave;
            ctrlPkg::MultStart:  nextState = ctrlPkg::MultWait;
            ctrlPkg::MultWait: begin
                if (multEnd) begin
                    nextState = ctrlPkg::MultResult;
                end
            end
            ctrlPkg::DivStart:   nextState = ctrlPkg::DivWait;
            ctrlPkg::DivWait: begin
                if (divEnd) begin
                    nextState = ctrlPkg::DivResult;
                end
            end
            ctrlPkg::BranchCompare: begin
                nextState = takeBranch ? ctrlPkg::BranchTake : ctrlPkg::Fetch;
            end
            ctrlPkg::BreakCalc:  nextState = ctrlPkg::BreakPc;
            default:             nextState = ctrlPkg::Fetch; // Last cycle of each path
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ctrlPkg::Fetch;
            fetchCnt   <= '0;
            branchKind <= ctrlPkg::BrEq;
        end else begin
            state <= nextState;
            if (state == ctrlPkg::Fetch && !fetchDone) begin
                fetchCnt <= fetchCnt + 1'b1;
            end else begin
                fetchCnt <= '0;
            end
            if (state == ctrlPkg::Decode) begin
                branchKind <= decodedBranch;
            end
        end
    end

endmodule

/* controlEncoder.sv */
`timescale 1ns/1ps

module controlEncoder (
    input  ctrlPkg::ctrlStateT state,
    output logic               writePc,
    output logic               writeA,
    output logic               writeB,
    output logic               writeAluOut,
    output logic               writeInstruction,
    output logic               writeReg,
    output logic               writeHilo,
    output logic               multStart,
    output logic               divStart,
    output logic               hiloSel,
    output ctrlPkg::aluOpT     aluOp,
    output ctrlPkg::aluSrcAT   aluSrcA,
    output ctrlPkg::aluSrcBT   aluSrcB,
    output ctrlPkg::pcSrcT     pcSrc,
    output ctrlPkg::regDstT    regDst,
    output ctrlPkg::wbSrcT     wbSrc
);

    always_comb begin
        writePc          = 1'b0;
        writeA           = 1'b0;
        writeB           = 1'b0;
        writeAluOut      = 1'b0;
        writeInstruction = 1'b0;
        writeReg         = 1'b0;
        writeHilo        = 1'b0;
        multStart        = 1'b0;
        divStart         = 1'b0;
        hiloSel          = 1'b0; // 0 takes the multiplier result
        aluOp            = ctrlPkg::AluAdd;
        aluSrcA          = ctrlPkg::SrcAPc;
        aluSrcB          = ctrlPkg::SrcBRegB;
        pcSrc            = ctrlPkg::PcAluResult;
        regDst           = ctrlPkg::DstRd;
        wbSrc            = ctrlPkg::WbAluOut;
        case (state)
            ctrlPkg::Fetch: begin
                writeInstruction = 1'b1;
                writeAluOut      = 1'b1; // PC + 4
                aluSrcB          = ctrlPkg::SrcBFour;
            end
            ctrlPkg::FetchPc, ctrlPkg::BreakPc: begin
                writePc = 1'b1;
                pcSrc   = ctrlPkg::PcAluOut;
            end
            ctrlPkg::Precalc: begin
                writeAluOut = 1'b1; // Branch target
                aluSrcB     = ctrlPkg::SrcBOffset;
            end
            ctrlPkg::Decode: begin
                writeA = 1'b1;
                writeB = 1'b1;
            end
            ctrlPkg::ExecAdd, ctrlPkg::ExecSub, ctrlPkg::ExecAnd: begin
                writeAluOut = 1'b1;
                aluSrcA     = ctrlPkg::SrcARegA;
                case (state)
                    ctrlPkg::ExecSub: aluOp = ctrlPkg::AluSub;
                    ctrlPkg::ExecAnd: aluOp = ctrlPkg::AluAnd;
                    default:          aluOp = ctrlPkg::AluAdd;
                endcase
            end
            ctrlPkg::AddImm: begin
                writeAluOut = 1'b1;
                aluSrcA     = ctrlPkg::SrcARegA;
                aluSrcB     = ctrlPkg::SrcBImm;
            end
            ctrlPkg::SaveResult: writeReg = 1'b1;
            ctrlPkg::AddImmSave: begin
                writeReg = 1'b1;
                regDst   = ctrlPkg::DstRt;
            end
            ctrlPkg::MultStart:  multStart = 1'b1;
            ctrlPkg::DivStart:   divStart = 1'b1;
            ctrlPkg::MultResult: writeHilo = 1'b1;
            ctrlPkg::DivResult: begin
                writeHilo = 1'b1;
                hiloSel   = 1'b1;
            end
            ctrlPkg::Mfhi: begin
                writeReg = 1'b1;
                wbSrc    = ctrlPkg::WbHi;
            end
            ctrlPkg::Mflo: begin
                writeReg = 1'b1;
                wbSrc    = ctrlPkg::WbLo;
            end
            ctrlPkg::BranchCompare: begin
                aluSrcA = ctrlPkg::SrcARegA;
                aluOp   = ctrlPkg::AluCompare;
            end
            ctrlPkg::BranchTake: begin
                writePc     = 1'b1;
                writeAluOut = 1'b1;
                pcSrc       = ctrlPkg::PcAluOut;
            end
            ctrlPkg::BreakCalc: begin
                writeAluOut = 1'b1; // PC - 4
                aluSrcB     = ctrlPkg::SrcBFour;
                aluOp       = ctrlPkg::AluSub;
            end
            default: begin
            end
        endcase
    end

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit #(
    parameter int FetchWait = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  ctrlPkg::opcodeT  opcode,
    input  ctrlPkg::functT   funct,
    input  logic             gt,
    input  logic             lt,
    input  logic             et,
    input  logic             multEnd,
    input  logic             divEnd,
    output logic             writePc,
    output logic             writeA,
    output logic             writeB,
    output logic             writeAluOut,
    output logic             writeInstruction,
    output logic             writeReg,
    output logic             writeHilo,
    output logic             multStart,
    output logic             divStart,
    output logic             hiloSel,
    output ctrlPkg::aluOpT   aluOp,
    output ctrlPkg::aluSrcAT aluSrcA,
    output ctrlPkg::aluSrcBT aluSrcB,
    output ctrlPkg::pcSrcT   pcSrc,
    output ctrlPkg::regDstT  regDst,
    output ctrlPkg::wbSrcT   wbSrc
);

    ctrlPkg::ctrlStateT  decodedState;
    ctrlPkg::branchKindT decodedBranch;
    ctrlPkg::ctrlStateT  state;

    instrDecoder instrDecoder_inst (
        .opcode        (opcode),
        .funct         (funct),
        .decodedState  (decodedState),
        .decodedBranch (decodedBranch)
    );

    controlSequencer #(
        .FetchWait (FetchWait)
    ) controlSequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .decodedState  (decodedState),
        .decodedBranch (decodedBranch),
        .gt            (gt),
        .lt            (lt),
        .et            (et),
        .multEnd       (multEnd),
        .divEnd        (divEnd),
        .state         (state)
    );

    controlEncoder controlEncoder_inst (
        .state            (state),
        .writePc          (writePc),
        .writeA           (writeA),
        .writeB           (writeB),
        .writeAluOut      (writeAluOut),
        .writeInstruction (writeInstruction),
        .writeReg         (writeReg),
        .writeHilo        (writeHilo),
        .multStart        (multStart),
        .divStart         (divStart),
        .hiloSel          (hiloSel),
        .aluOp            (aluOp),
        .aluSrcA          (aluSrcA),
        .aluSrcB          (aluSrcB),
        .pcSrc            (pcSrc),
        .regDst           (regDst),
        .wbSrc            (wbSrc)
    );

endmodule

/* controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;

    localparam int FetchWait  = 3;
    localparam int CycleLimit = 64; // Longest window plus margin

    logic              clk;
    logic              reset;
    ctrlPkg::opcodeT   opcode;
    ctrlPkg::functT    funct;
    logic              gt;
    logic              lt;
    logic              et;
    logic              multEnd;
    logic              divEnd;
    logic              writePc;
    logic              writeA;
    logic              writeB;
    logic              writeAluOut;
    logic              writeInstruction;
    logic              writeReg;
    logic              writeHilo;
    logic              multStart;
    logic              divStart;
    logic              hiloSel;
    ctrlPkg::aluOpT    aluOp;
    ctrlPkg::aluSrcAT  aluSrcA;
    ctrlPkg::aluSrcBT  aluSrcB;
    ctrlPkg::pcSrcT    pcSrc;
    ctrlPkg::regDstT   regDst;
    ctrlPkg::wbSrcT    wbSrc;

    string  caseName;
    int     caseOp;
    int     caseFunct;
    int     caseGt;
    int     caseLt;
    int     caseEt;
    int     expAluOp;
    int     expReg;
    int     expDst;
    int     expWb;
    int     expPc;
    int     expSel;
    int     expHilo;
    int     expExtra; // Cycles after Decode, not counting the unit delay
    integer seed;
    int     caseCount;

    controlUnit #(
        .FetchWait (FetchWait)
    ) controlUnit_inst (
        .clk              (clk),
        .reset            (reset),
        .opcode           (opcode),
        .funct            (funct),
        .gt               (gt),
        .lt               (lt),
        .et               (et),
        .multEnd          (multEnd),
        .divEnd           (divEnd),
        .writePc          (writePc),
        .writeA           (writeA),
        .writeB           (writeB),
        .writeAluOut      (writeAluOut),
        .writeInstruction (writeInstruction),
        .writeReg         (writeReg),
        .writeHilo        (writeHilo),
        .multStart        (multStart),
        .divStart         (divStart),
        .hiloSel          (hiloSel),
        .aluOp            (aluOp),
        .aluSrcA          (aluSrcA),
        .aluSrcB          (aluSrcB),
        .pcSrc            (pcSrc),
        .regDst           (regDst),
        .wbSrc            (wbSrc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        if (expected != actual) begin
            stopRun($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                              caseName, what, expected, actual));
        end
    endtask

    // Entered at the falling edge of the first Fetch cycle of the window
    task automatic runCase;
        int             cycles;
        int             nReg;
        int             nPc;
        int             nHilo;
        int             nStart;
        int             nWriteA;
        int             nWriteB;
        int             endDelay;
        int             delayUsed;
        logic           sawGap;
        logic           endRaised;
        logic           endIsDiv;
        logic           done;
        logic [31:0]    rnd;
        ctrlPkg::aluOpT exAluOp;
        ctrlPkg::regDstT seenDst;
        ctrlPkg::wbSrcT seenWb;
        logic           seenSel;
        cycles    = 1;
        nReg      = 0;
        nPc       = 0;
        nHilo     = 0;
        nStart    = 0;
        nWriteA   = 0;
        nWriteB   = 0;
        endDelay  = 0;
        delayUsed = 0;
        sawGap    = 1'b0;
        endRaised = 1'b0;
        endIsDiv  = 1'b0;
        done      = 1'b0;
        exAluOp   = '0; // 0 means no execute ALU cycle seen
        seenDst   = '0;
        seenWb    = '0;
        seenSel   = 1'b0;
        @(posedge clk);
        opcode <= ctrlPkg::opcodeT'(caseOp);
        funct  <= ctrlPkg::functT'(caseFunct);
        gt     <= caseGt[0];
        lt     <= caseLt[0];
        et     <= caseEt[0];
        while (!done) begin
            @(negedge clk);
            if (writeInstruction && sawGap) begin
                done = 1'b1; // Next instruction fetch reached
            end else begin
                if (!writeInstruction) begin
                    sawGap = 1'b1;
                end
                if (writeReg) begin
                    nReg++;
                    seenDst = regDst;
                    seenWb  = wbSrc;
                end
                if (writeA) begin
                    nWriteA++;
                end
                if (writeB) begin
                    nWriteB++;
                end
                if (writePc) begin
                    nPc++;
                    checkValue("pcSrc", int'(ctrlPkg::PcAluOut), int'(pcSrc));
                end
                if (writeHilo) begin
                    if (!endRaised) begin
                        stopRun($sformatf("%s: writeHilo came before the end pulse", caseName));
                    end
                    nHilo++;
                    seenSel = hiloSel;
                end
                if (aluSrcA == ctrlPkg::SrcARegA ||
                    (writeAluOut && !writeInstruction && aluSrcB == ctrlPkg::SrcBFour)) begin
                    exAluOp = aluOp;
                end
                if (multStart || divStart) begin
                    nStart++;
                    endIsDiv  = divStart;
                    rnd       = $random(seed);
                    endDelay  = int'(rnd[2:0]) + 1;
                    delayUsed = endDelay;
                end
                cycles++;
                if (cycles > CycleLimit) begin
                    stopRun($sformatf("%s: timeout waiting for the next fetch", caseName));
                end
                @(posedge clk);
                multEnd <= 1'b0;
                divEnd  <= 1'b0;
                if (endDelay > 0) begin
                    endDelay--;
                    if (endDelay == 0) begin
                        if (endIsDiv) begin
                            divEnd <= 1'b1;
                        end else begin
                            multEnd <= 1'b1;
                        end
                        endRaised = 1'b1;
                    end
                end
            end
        end
        checkValue("window length", FetchWait + 3 + expExtra + delayUsed, cycles);
        checkValue("writeReg count", expReg, nReg);
        checkValue("writePc count", expPc, nPc);
        checkValue("writeHilo count", expHilo, nHilo);
        checkValue("start pulses", expHilo, nStart);
        checkValue("writeA count", 1, nWriteA);
        checkValue("writeB count", 1, nWriteB);
        checkValue("aluOp", expAluOp, int'(exAluOp));
        if (expReg > 0) begin
            checkValue("regDst", expDst, int'(seenDst));
            checkValue("wbSrc", expWb, int'(seenWb));
        end
        if (expHilo > 0) begin
            checkValue("hiloSel", expSel, int'(seenSel));
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        seed      = 32'h7c6bef5d;
        reset     = 1'b1;
        opcode    = '0;
        funct     = '0;
        gt        = 1'b0;
        lt        = 1'b0;
        et        = 1'b0;
        multEnd   = 1'b0;
        divEnd    = 1'b0;
        caseCount = 0;
        caseName  = "reset";
        fd = $fopen("ctrl_cases.txt", "r");
        if (fd == 0) begin
            stopRun("Cannot open ctrl_cases.txt");
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("writeInstruction", 1, int'(writeInstruction));
        checkValue("writeAluOut", 1, int'(writeAluOut));
        checkValue("aluSrcB", int'(ctrlPkg::SrcBFour), int'(aluSrcB));
        checkValue("writeReg", 0, int'(writeReg));
        checkValue("writePc", 0, int'(writePc));
        checkValue("writeHilo", 0, int'(writeHilo));
        checkValue("multStart", 0, int'(multStart));
        checkValue("divStart", 0, int'(divStart));
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %d %d %d %d %d %d %d %d %d %d %d",
                            caseName, caseOp, caseFunct, caseGt, caseLt, caseEt,
                            expAluOp, expReg, expDst, expWb, expPc, expSel,
                            expHilo, expExtra);
                if (n != 14) begin
                    stopRun($sformatf("Malformed line in ctrl_cases.txt: %s", line));
                end
                runCase();
                caseCount++;
            end
        end
        $fclose(fd);
        if (caseCount == 0) begin
            stopRun("No cases were read from ctrl_cases.txt");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* ctrl_cases.txt */
# name opcode funct gt lt et | aluOp writeRegs regDst wbSrc writePcs hiloSel writeHilos extra
# opcode and funct in hex, the rest in decimal; aluOp 0 means no execute ALU cycle
add      00 20 0 0 0 1 1 0 0 1 0 0 2
sub      00 22 0 0 0 2 1 0 0 1 0 0 2
and      00 24 0 0 0 3 1 0 0 1 0 0 2
addi     08 00 0 0 0 1 1 3 0 1 0 0 2
addiu    09 00 0 0 0 1 1 3 0 1 0 0 2
beqTake  04 00 0 0 1 7 0 0 0 2 0 0 2
beqSkip  04 00 1 0 0 7 0 0 0 1 0 0 1
bneTake  05 00 0 1 0 7 0 0 0 2 0 0 2
bneSkip  05 00 0 0 1 7 0 0 0 1 0 0 1
bleTake  06 00 0 1 0 7 0 0 0 2 0 0 2
bleEq    06 00 0 0 1 7 0 0 0 2 0 0 2
bleSkip  06 00 1 0 0 7 0 0 0 1 0 0 1
bgtTake  07 00 1 0 0 7 0 0 0 2 0 0 2
bgtSkip  07 00 0 0 1 7 0 0 0 1 0 0 1
mult     00 18 0 0 0 0 0 0 0 1 0 1 2
div      00 1a 0 0 0 0 0 0 0 1 1 1 2
mfhi     00 10 0 0 0 0 1 0 2 1 0 0 1
mflo     00 12 0 0 0 0 1 0 1 1 0 0 1
break    00 0d 0 0 0 2 0 0 0 2 0 0 2
unknown  3f 00 0 0 0 0 0 0 0 1 0 0 0

/* list.f */
ctrlPkg.sv
instrDecoder.sv
controlSequencer.sv
controlEncoder.sv
controlUnit.sv
controlUnitTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps --top-module controlUnitTb -f list.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
